//--- rtl/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // MIPS opcode field, anything else is an illegal opcode
    typedef enum logic [5:0] {
        opRFormat = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opBle     = 6'h06,
        opBgt     = 6'h07,
        opAddi    = 6'h08,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnSlt = 6'h2a
    } funct_t;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } instrFields_t;

    typedef struct packed {
        logic overflow;
        logic equal;
        logic greater;
    } aluFlags_t;

    typedef enum logic [2:0] {
        aluPass    = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluAnd     = 3'd3,
        aluCompare = 3'd7 // slt style compare, also sets equal/greater
    } aluOp_t;

    typedef enum logic [2:0] {
        aluReg, aluImm, setLess, branch, jump, load, store, illegal
    } instrClass_t;

    typedef enum logic [1:0] {brEq, brNe, brLe, brGt} branchCond_t;

    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        branchCond_t branchCond;
        logic        trapsOverflow;
        logic        useImm;
        logic        destRt;  // write rt instead of rd
    } decodedInstr_t;

    typedef enum logic [4:0] {
        fetch1, fetch2, fetch3, decode1, decode2, execute,
        writeBack, memWait, loadWrite, storeAddr, storeWrite,
        branchCheck, branchTaken,
        exc1, exc2, excWait, excLoad, finish
    } ctrlState_t;

    typedef enum logic {causeOpcode, causeOverflow} excCause_t;

    // datapath mux selects
    typedef enum logic {srcAPc, srcARegA} aluSrcA_t;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBBranchOff} aluSrcB_t;
    typedef enum logic {dstRt, dstRd} regDst_t;
    typedef enum logic [1:0] {m2rAluOut, m2rMemData, m2rAluResult} memToReg_t;
    typedef enum logic [1:0] {
        pcSrcAluResult, pcSrcAluOut, pcSrcJumpTarget, pcSrcMemData
    } pcSource_t;
    typedef enum logic [1:0] {
        iordPc, iordAluOut, iordOpcodeVector, iordOverflowVector
    } iord_t;

    typedef struct packed {
        logic      memWrite;
        logic      pcWrite;
        logic      irWrite;
        logic      regWrite;
        logic      abWrite;
        logic      aluOutWrite;
        logic      epcWrite;
        aluOp_t    aluOp;
        aluSrcA_t  aluSrcA;
        aluSrcB_t  aluSrcB;
        regDst_t   regDst;
        memToReg_t memToReg;
        pcSource_t pcSource;
        iord_t     iord;
    } ctrlWord_t;

    localparam ctrlWord_t idleCtrl = '{
        memWrite: 1'b0, pcWrite: 1'b0, irWrite: 1'b0, regWrite: 1'b0,
        abWrite: 1'b0, aluOutWrite: 1'b0, epcWrite: 1'b0,
        aluOp: aluPass, aluSrcA: srcAPc, aluSrcB: srcBRegB, regDst: dstRt,
        memToReg: m2rAluOut, pcSource: pcSrcAluResult, iord: iordPc
    };

endpackage

//--- rtl/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  cpuCtrlPkg::instrFields_t  instr,
    output cpuCtrlPkg::decodedInstr_t decoded
);
    import cpuCtrlPkg::*;

    always_comb begin
        // unknown opcodes fall through as illegal
        decoded.instrClass    = illegal;
        decoded.aluOp         = aluPass;
        decoded.branchCond    = brEq;
        decoded.trapsOverflow = 1'b0;
        decoded.useImm        = 1'b0;
        decoded.destRt        = 1'b0;

        case (instr.opcode)
            opRFormat: begin
                case (instr.funct)
                    fnAdd: begin
                        decoded.instrClass    = aluReg;
                        decoded.aluOp         = aluAdd;
                        decoded.trapsOverflow = 1'b1;
                    end
                    fnSub: begin
                        decoded.instrClass    = aluReg;
                        decoded.aluOp         = aluSub;
                        decoded.trapsOverflow = 1'b1;
                    end
                    fnAnd: begin
                        decoded.instrClass = aluReg;
                        decoded.aluOp      = aluAnd;
                    end
                    fnSlt: begin
                        decoded.instrClass = setLess;
                        decoded.aluOp      = aluCompare;
                    end
                    default: decoded.instrClass = illegal; // unknown funct
                endcase
            end
            opAddi, opAddiu: begin
                decoded.instrClass    = aluImm;
                decoded.aluOp         = aluAdd;
                decoded.useImm        = 1'b1;
                decoded.destRt        = 1'b1;
                decoded.trapsOverflow = (instr.opcode == opAddi); // addiu never traps
            end
            opSlti: begin
                decoded.instrClass = setLess;
                decoded.aluOp      = aluCompare;
                decoded.useImm     = 1'b1;
                decoded.destRt     = 1'b1;
            end
            opBeq, opBne, opBle, opBgt: begin
                decoded.instrClass = branch;
                decoded.aluOp      = aluCompare;
                case (instr.opcode)
                    opBne:   decoded.branchCond = brNe;
                    opBle:   decoded.branchCond = brLe;
                    opBgt:   decoded.branchCond = brGt;
                    default: decoded.branchCond = brEq;
                endcase
            end
            opJ: decoded.instrClass = jump;
            opLw, opSw: begin
                decoded.instrClass = (instr.opcode == opLw) ? load : store;
                decoded.aluOp      = aluAdd; // base + offset
                decoded.useImm     = 1'b1;
                decoded.destRt     = 1'b1;
            end
            default: decoded.instrClass = illegal;
        endcase
    end

endmodule

//--- rtl/ctrlSequencer.sv
`timescale 1ns/1ps

module ctrlSequencer #(
    parameter int memWaitCycles = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  cpuCtrlPkg::decodedInstr_t decoded,
    input  cpuCtrlPkg::aluFlags_t     flags,
    output cpuCtrlPkg::ctrlState_t    state,
    output cpuCtrlPkg::excCause_t     cause
);
    import cpuCtrlPkg::*;

    localparam int cntWidth = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;
    localparam logic [cntWidth-1:0] lastWait = cntWidth'(memWaitCycles - 1);

    ctrlState_t          nextState;
    excCause_t           nextCause;
    logic [cntWidth-1:0] waitCnt;
    logic                waitDone;
    logic                inWait;
    logic                branchHolds;

    assign inWait   = (state == memWait) || (state == excWait);
    assign waitDone = (waitCnt == lastWait);

    // branch condition from the compare done in execute
    always_comb begin
        case (decoded.branchCond)
            brEq:    branchHolds = flags.equal;
            brNe:    branchHolds = !flags.equal;
            brLe:    branchHolds = !flags.greater;
            default: branchHolds = flags.greater;
        endcase
    end

    always_comb begin
        nextState = state;
        nextCause = cause;

        case (state)
            fetch1:  nextState = fetch2;
            fetch2:  nextState = fetch3;
            fetch3:  nextState = decode1;
            decode1: nextState = decode2;
            decode2: nextState = execute;
            execute: begin
                case (decoded.instrClass)
                    aluReg, aluImm:  nextState = writeBack;
                    setLess, jump:   nextState = finish;
                    branch:          nextState = branchCheck;
                    load:            nextState = memWait;
                    store:           nextState = storeAddr;
                    default: begin
                        nextState = exc1;
                        nextCause = causeOpcode;
                    end
                endcase
            end
            writeBack: begin
                if (decoded.trapsOverflow && flags.overflow) begin
                    nextState = exc1;
                    nextCause = causeOverflow;
                end else begin
                    nextState = finish;
                end
            end
            storeAddr: nextState = memWait;
            memWait: begin
                if (waitDone) begin
                    nextState = (decoded.instrClass == store) ? storeWrite : loadWrite;
                end
            end
            loadWrite, storeWrite: nextState = finish;
            branchCheck: nextState = branchHolds ? branchTaken : finish;
            branchTaken: nextState = finish;
            exc1: nextState = exc2;
            exc2: nextState = excWait;
            excWait: begin
                if (waitDone) begin
                    nextState = excLoad;
                end
            end
            excLoad: nextState = finish;
            finish:  nextState = fetch1;
            default: nextState = fetch1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fetch1;
            cause   <= causeOpcode;
            waitCnt <= '0;
        end else begin
            state <= nextState;
            cause <= nextCause; // only moves on entry to exc1
            if (inWait && !waitDone) begin
                waitCnt <= waitCnt + 1'b1;
            end else begin
                waitCnt <= '0;
            end
        end
    end

endmodule

//--- rtl/ctrlWordGen.sv
`timescale 1ns/1ps

module ctrlWordGen (
    input  cpuCtrlPkg::ctrlState_t    state,
    input  cpuCtrlPkg::excCause_t     cause,
    input  cpuCtrlPkg::decodedInstr_t decoded,
    output cpuCtrlPkg::ctrlWord_t     ctrl
);
    import cpuCtrlPkg::*;

    always_comb begin
        ctrl = idleCtrl;

        case (state)
            fetch1: begin
                ctrl.iord    = iordPc;
                ctrl.aluSrcA = srcAPc;
                ctrl.aluSrcB = srcBFour;
                ctrl.aluOp   = aluAdd;
            end
            fetch2: begin
                // hold pc+4 on the ALU while the PC takes it
                ctrl.aluSrcA  = srcAPc;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluAdd;
                ctrl.pcSource = pcSrcAluResult;
                ctrl.pcWrite  = 1'b1;
            end
            fetch3: ctrl.irWrite = 1'b1;
            decode1: begin
                // speculative branch target into aluOut
                ctrl.aluSrcA     = srcAPc;
                ctrl.aluSrcB     = srcBBranchOff;
                ctrl.aluOp       = aluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            decode2: ctrl.abWrite = 1'b1;
            execute: begin
                ctrl.aluOp   = decoded.aluOp;
                ctrl.aluSrcA = srcARegA;
                if (decoded.useImm) begin
                    ctrl.aluSrcB = srcBImm;
                end
                case (decoded.instrClass)
                    aluReg, aluImm, store: ctrl.aluOutWrite = 1'b1;
                    setLess: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.memToReg = m2rAluResult;
                        if (!decoded.destRt) begin
                            ctrl.regDst = dstRd;
                        end
                    end
                    jump: begin
                        ctrl.pcWrite  = 1'b1;
                        ctrl.pcSource = pcSrcJumpTarget;
                    end
                    load: ctrl.iord = iordAluOut;
                    default: ;
                endcase
            end
            writeBack: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = m2rAluOut;
                if (!decoded.destRt) begin
                    ctrl.regDst = dstRd;
                end
            end
            loadWrite: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = m2rMemData;
                ctrl.regDst   = dstRt;
            end
            storeAddr: ctrl.iord = iordAluOut;
            storeWrite: begin
                ctrl.iord     = iordAluOut; // address still needed for the write
                ctrl.memWrite = 1'b1;
            end
            branchTaken: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcSrcAluOut;
            end
            exc1: begin
                // EPC gets pc-4, the faulting instruction
                ctrl.epcWrite = 1'b1;
                ctrl.aluSrcA  = srcAPc;
                ctrl.aluSrcB  = srcBFour;
                ctrl.aluOp    = aluSub;
            end
            exc2: begin
                if (cause == causeOverflow) begin
                    ctrl.iord = iordOverflowVector;
                end else begin
                    ctrl.iord = iordOpcodeVector;
                end
            end
            excLoad: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcSrcMemData; // handler address from memory
            end
            default: ctrl = idleCtrl; // memWait, excWait, branchCheck, finish
        endcase
    end

endmodule

//--- rtl/cpuCtrlUnit.sv
`timescale 1ns/1ps

module cpuCtrlUnit #(
    parameter int memWaitCycles = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  cpuCtrlPkg::instrFields_t instr,
    input  cpuCtrlPkg::aluFlags_t    flags,
    output cpuCtrlPkg::ctrlWord_t    ctrl
);
    import cpuCtrlPkg::*;

    decodedInstr_t decodedNow;
    decodedInstr_t decodedReg;
    ctrlState_t    state;
    excCause_t     cause;

    instrDecode instrDecode0 (
        .instr  (instr),
        .decoded(decodedNow)
    );

    // IR is stable from decode2 on, hold its decode for the rest of the instruction
    always_ff @(posedge clk) begin
        if (state == decode2) begin
            decodedReg <= decodedNow;
        end
    end

    ctrlSequencer #(
        .memWaitCycles(memWaitCycles)
    ) ctrlSequencer0 (
        .clk    (clk),
        .reset  (reset),
        .decoded(decodedReg),
        .flags  (flags),
        .state  (state),
        .cause  (cause)
    );

    ctrlWordGen ctrlWordGen0 (
        .state  (state),
        .cause  (cause),
        .decoded(decodedReg),
        .ctrl   (ctrl)
    );

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

//--- tests/cpuCtrlUnitTb.sv
`timescale 1ns/1ps

module cpuCtrlUnitTb;
    import cpuCtrlPkg::*;

    localparam int memWaitCycles = 3;
    localparam int longestPath   = 15;

    logic         clk;
    logic         reset;
    instrFields_t instr;
    aluFlags_t    flags;
    ctrlWord_t    ctrl;
    ctrlWord_t    expected;

    instrFields_t progInstr[$];
    aluFlags_t    progFlags[$];
    integer       seed;
    int           errorCount = 0;
    int           checkCount = 0;
    int           cycleCount = 0;
    int           timeoutCycles;
    int           curStep;
    int           instrIdx;
    bit           active = 1'b0;

    clockGen clockGen0 (
        .clk  (clk),
        .reset(reset)
    );

    cpuCtrlUnit #(
        .memWaitCycles(memWaitCycles)
    ) dut0 (
        .clk  (clk),
        .reset(reset),
        .instr(instr),
        .flags(flags),
        .ctrl (ctrl)
    );

    function automatic instrFields_t makeInstr(input logic [5:0] op, input logic [5:0] fn);
        return instrFields_t'({op, fn});
    endfunction

    function automatic instrClass_t classOf(input instrFields_t i);
        case (i.opcode)
            opRFormat: begin
                case (i.funct)
                    fnAdd, fnSub, fnAnd: return aluReg;
                    fnSlt:               return setLess;
                    default:             return illegal;
                endcase
            end
            opAddi, opAddiu:            return aluImm;
            opSlti:                     return setLess;
            opBeq, opBne, opBle, opBgt: return branch;
            opJ:                        return jump;
            opLw:                       return load;
            opSw:                       return store;
            default:                    return illegal;
        endcase
    endfunction

    function automatic aluOp_t aluOpOf(input instrFields_t i);
        case (i.opcode)
            opRFormat: begin
                case (i.funct)
                    fnAdd:   return aluAdd;
                    fnSub:   return aluSub;
                    fnAnd:   return aluAnd;
                    fnSlt:   return aluCompare;
                    default: return aluPass;
                endcase
            end
            opAddi, opAddiu, opLw, opSw:        return aluAdd;
            opSlti, opBeq, opBne, opBle, opBgt: return aluCompare;
            default:                            return aluPass;
        endcase
    endfunction

    function automatic logic traps(input instrFields_t i);
        return (i.opcode == opAddi) ||
               (i.opcode == opRFormat && (i.funct == fnAdd || i.funct == fnSub));
    endfunction

    function automatic logic branchCondHolds(input instrFields_t i, input aluFlags_t f);
        case (i.opcode)
            opBeq:   return f.equal;
            opBne:   return !f.equal;
            opBle:   return !f.greater;
            default: return f.greater;
        endcase
    endfunction

    // state at a given step of one instruction
    function automatic ctrlState_t pathState(
        input instrFields_t i, input aluFlags_t f, input int step
    );
        ctrlState_t seq[$];
        logic       excPath;
        excPath = 1'b0;
        seq = '{fetch1, fetch2, fetch3, decode1, decode2, execute};
        case (classOf(i))
            aluReg, aluImm: begin
                seq.push_back(writeBack);
                excPath = traps(i) && f.overflow;
            end
            setLess, jump: ;
            branch: begin
                seq.push_back(branchCheck);
                if (branchCondHolds(i, f)) begin
                    seq.push_back(branchTaken);
                end
            end
            load: begin
                repeat (memWaitCycles) seq.push_back(memWait);
                seq.push_back(loadWrite);
            end
            store: begin
                seq.push_back(storeAddr);
                repeat (memWaitCycles) seq.push_back(memWait);
                seq.push_back(storeWrite);
            end
            default: excPath = 1'b1;
        endcase
        if (excPath) begin
            seq.push_back(exc1);
            seq.push_back(exc2);
            repeat (memWaitCycles) seq.push_back(excWait);
            seq.push_back(excLoad);
        end
        seq.push_back(finish);
        if (step < seq.size()) begin
            return seq[step];
        end
        return finish;
    endfunction

    function automatic int pathLen(input instrFields_t i, input aluFlags_t f);
        int k;
        k = 0;
        while (k < longestPath && pathState(i, f, k) != finish) begin
            k++;
        end
        return k + 1;
    endfunction

    function automatic ctrlWord_t refCtrl(
        input instrFields_t i, input aluFlags_t f, input int step
    );
        ctrlWord_t   w;
        instrClass_t kind;
        logic        immForm; // I-format, writes rt
        w = idleCtrl;
        kind = classOf(i);
        immForm = (i.opcode != opRFormat);
        case (pathState(i, f, step))
            fetch1: begin
                w.aluSrcB = srcBFour;
                w.aluOp   = aluAdd;
            end
            fetch2: begin
                w.aluSrcB = srcBFour;
                w.aluOp   = aluAdd;
                w.pcWrite = 1'b1;
            end
            fetch3: w.irWrite = 1'b1;
            decode1: begin
                w.aluSrcB     = srcBBranchOff;
                w.aluOp       = aluAdd;
                w.aluOutWrite = 1'b1;
            end
            decode2: w.abWrite = 1'b1;
            execute: begin
                w.aluOp   = aluOpOf(i);
                w.aluSrcA = srcARegA;
                if (immForm && kind inside {aluImm, setLess, load, store}) begin
                    w.aluSrcB = srcBImm;
                end
                case (kind)
                    aluReg, aluImm, store: w.aluOutWrite = 1'b1;
                    setLess: begin
                        w.regWrite = 1'b1;
                        w.memToReg = m2rAluResult;
                        w.regDst   = immForm ? dstRt : dstRd;
                    end
                    jump: begin
                        w.pcWrite  = 1'b1;
                        w.pcSource = pcSrcJumpTarget;
                    end
                    load:    w.iord = iordAluOut;
                    default: ;
                endcase
            end
            writeBack: begin
                w.regWrite = 1'b1;
                w.regDst   = immForm ? dstRt : dstRd;
            end
            loadWrite: begin
                w.regWrite = 1'b1;
                w.memToReg = m2rMemData;
            end
            storeAddr: w.iord = iordAluOut;
            storeWrite: begin
                w.iord     = iordAluOut;
                w.memWrite = 1'b1;
            end
            branchTaken: begin
                w.pcWrite  = 1'b1;
                w.pcSource = pcSrcAluOut;
            end
            exc1: begin
                w.epcWrite = 1'b1;
                w.aluSrcB  = srcBFour;
                w.aluOp    = aluSub;
            end
            // only alu classes reach exc via overflow
            exc2: w.iord = (kind inside {aluReg, aluImm}) ? iordOverflowVector : iordOpcodeVector;
            excLoad: begin
                w.pcWrite  = 1'b1;
                w.pcSource = pcSrcMemData;
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("ERROR: %s = 0x%h, expected 0x%h at %0t (instr %0d, step %0d)",
                     name, got, exp, $time, instrIdx, curStep);
        end
    endtask

    task automatic addInstr(input logic [5:0] op, input logic [5:0] fn, input logic ovf);
        logic [31:0] r;
        aluFlags_t   f;
        r = $random(seed);
        f.overflow = ovf;
        f.equal    = r[0];
        f.greater  = r[1];
        progInstr.push_back(makeInstr(op, fn));
        progFlags.push_back(f);
    endtask

    // compare on the falling edge
    always @(negedge clk) begin
        if (reset && cycleCount > 0) begin
            checkValue("ctrl write enables in reset",
                       32'({ctrl.memWrite, ctrl.pcWrite, ctrl.irWrite, ctrl.regWrite,
                            ctrl.abWrite, ctrl.aluOutWrite, ctrl.epcWrite}), 32'h0);
        end else if (active) begin
            expected = refCtrl(instr, flags, curStep);
            checkValue("ctrl", 32'(ctrl), 32'(expected));
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        instr = makeInstr(opRFormat, fnAdd);
        flags = '0;
        curStep = 0;
        instrIdx = 0;
        seed = 32'ha1ef_62a5;

        addInstr(opRFormat, fnAdd, 1'b0);
        addInstr(opRFormat, fnSub, 1'b0);
        addInstr(opRFormat, fnAnd, 1'b0);
        addInstr(opAddi, 6'h00, 1'b0);
        addInstr(opAddiu, 6'h00, 1'b0);
        addInstr(opRFormat, fnSlt, 1'b0);
        addInstr(opSlti, 6'h00, 1'b0);
        // overflow high in writeBack
        addInstr(opRFormat, fnAdd, 1'b1);
        addInstr(opRFormat, fnSub, 1'b1);
        addInstr(opAddi, 6'h00, 1'b1);
        addInstr(opAddiu, 6'h00, 1'b1);
        for (int k = 0; k < 6; k++) begin
            addInstr(opBeq, 6'h00, 1'b0);
            addInstr(opBne, 6'h00, 1'b0);
            addInstr(opBle, 6'h00, 1'b0);
            addInstr(opBgt, 6'h00, 1'b0);
        end
        addInstr(opLw, 6'h00, 1'b0);
        addInstr(opSw, 6'h00, 1'b0);
        addInstr(opJ, 6'h00, 1'b0);
        addInstr(6'h3f, 6'h00, 1'b0); // unknown opcode
        addInstr(opRFormat, 6'h01, 1'b0); // unknown funct
        addInstr(opRFormat, fnAdd, 1'b0);
        timeoutCycles = progInstr.size() * longestPath + 50;

        @(negedge reset);
        active = 1'b1;
        for (int n = 0; n < progInstr.size(); n++) begin
            instrIdx = n;
            instr = progInstr[n];
            flags = progFlags[n];
            for (int s = 0; s < pathLen(progInstr[n], progFlags[n]); s++) begin
                curStep = s;
                @(posedge clk);
                #10;
            end
        end
        active = 1'b0;

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- cpuCtrlUnit.f
rtl/cpuCtrlPkg.sv
rtl/instrDecode.sv
rtl/ctrlSequencer.sv
rtl/ctrlWordGen.sv
rtl/cpuCtrlUnit.sv
tests/clockGen.sv
tests/cpuCtrlUnitTb.sv

//--- run.sh
#!/bin/bash
# build and run the testbench, status follows the log
rm -f sim.log
verilator --binary --timing --top-module cpuCtrlUnitTb -f cpuCtrlUnit.f -o simv \
    && ./obj_dir/simv > sim.log \
    && cat sim.log \
    && ! grep -q "TESTBENCH FAILED" sim.log \
    || { echo "simulation run did not pass"; exit 1; }
